//--- Bender.yml
package:
  name: mips_core

sources:
  - isa_pkg.sv
  - core_pkg.sv
  - datapath_ctrl_if.sv
  - register_file.sv
  - alu.sv
  - shifter.sv
  - control_fsm.sv
  - datapath.sv
  - mips_core.sv
  - target: test
    files:
      - mips_core_checker.sv
      - tb_mips_core.sv

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  isa_pkg::word_t    i_a,
	input  isa_pkg::word_t    i_b,
	input  core_pkg::alu_op_t i_op,
	output isa_pkg::word_t    o_result,
	output logic              o_equal,
	output logic              o_greater
);
	import isa_pkg::*;
	import core_pkg::*;

	logic less;

	assign less = $signed(i_a) < $signed(i_b);

	always_comb begin
		case (i_op)
			ALU_ADD:  o_result = i_a + i_b;
			ALU_SUB:  o_result = i_a - i_b;
			ALU_AND:  o_result = i_a & i_b;
			ALU_CMP:  o_result = word_t'(less);
			ALU_PASS: o_result = i_b;
			default:  o_result = i_b;
		endcase
	end

	// Flags are valid whatever the operation.
	assign o_equal   = (i_a == i_b);
	assign o_greater = $signed(i_a) > $signed(i_b);

endmodule

`default_nettype wire

//--- control_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module control_fsm (
	input  logic clock,
	input  logic reset,
	input  logic i_fetch_valid,
	input  logic i_wb_credit,
	output logic o_fetch_req,
	output logic o_wb_valid,
	datapath_ctrl_if.ctrl ctrl
);
	import isa_pkg::*;
	import core_pkg::*;

	state_t  state;
	state_t  state_next;
	credit_t credits;
	logic    fetch_req_q;

	logic is_rtype;
	logic is_shift_var;
	logic is_shift;
	logic is_alu_r;
	logic is_imm;
	logic is_branch;
	logic branch_taken;
	alu_op_t exec_op;
	shift_op_t run_op;

	// ============================================================
	// Instruction decode
	// ============================================================

	assign is_rtype     = (ctrl.opcode == OP_RTYPE);
	assign is_shift_var = is_rtype && (ctrl.funct inside {FN_SLLV, FN_SRAV});
	assign is_shift     = is_shift_var || (is_rtype && (ctrl.funct inside {FN_SLL, FN_SRL, FN_SRA}));
	assign is_alu_r     = is_rtype && (ctrl.funct inside {FN_ADD, FN_SUB, FN_AND, FN_SLT});
	assign is_imm       = ctrl.opcode inside {OP_ADDI, OP_ADDIU};
	assign is_branch    = ctrl.opcode inside {OP_BEQ, OP_BNE, OP_BLE, OP_BGT};

	always_comb begin
		case (ctrl.funct)
			FN_SUB:  exec_op = ALU_SUB;
			FN_AND:  exec_op = ALU_AND;
			FN_SLT:  exec_op = ALU_CMP;
			default: exec_op = ALU_ADD;
		endcase
		if (is_imm) begin
			exec_op = ALU_ADD; // addi and addiu share the same path.
		end
	end

	always_comb begin
		case (ctrl.funct)
			FN_SLL, FN_SLLV: run_op = SH_LEFT;
			FN_SRL:          run_op = SH_RIGHT_LOG;
			default:         run_op = SH_RIGHT_ARITH;
		endcase
	end

	always_comb begin
		case (ctrl.opcode)
			OP_BEQ:  branch_taken = ctrl.equal;
			OP_BNE:  branch_taken = !ctrl.equal;
			OP_BLE:  branch_taken = !ctrl.greater;
			default: branch_taken = ctrl.greater;
		endcase
	end

	// ============================================================
	// Next state and control vector
	// ============================================================

	assign o_wb_valid  = (state == WRITEBACK) && (credits != '0);
	assign o_fetch_req = fetch_req_q;

	always_comb begin
		state_next         = state;
		ctrl.pc_write      = 1'b0;
		ctrl.ir_write      = 1'b0;
		ctrl.ab_write      = 1'b0;
		ctrl.alu_out_write = 1'b0;
		ctrl.alu_src_a     = 1'b0;
		ctrl.alu_src_b     = SRC_B_REG;
		ctrl.alu_op        = ALU_PASS;
		ctrl.shift_op      = SH_HOLD;
		ctrl.shift_amt_reg = 1'b0;
		ctrl.wb_sel        = is_shift ? WB_SHIFT : WB_ALU_OUT;
		ctrl.reg_write     = 1'b0;
		ctrl.reg_dst_rd    = is_rtype;

		case (state)
			FETCH: begin
				state_next = WAIT_INSTR;
			end
			WAIT_INSTR: begin
				// PC+4 goes into PC in the cycle the instruction arrives.
				ctrl.ir_write  = 1'b1;
				ctrl.pc_write  = i_fetch_valid;
				ctrl.alu_src_b = SRC_B_STEP;
				ctrl.alu_op    = ALU_ADD;
				if (i_fetch_valid) begin
					state_next = DECODE;
				end
			end
			DECODE: begin
				ctrl.ab_write      = 1'b1;
				ctrl.alu_out_write = 1'b1; // Branch target.
				ctrl.alu_src_b     = SRC_B_BRANCH;
				ctrl.alu_op        = ALU_ADD;
				if (is_alu_r || is_imm) begin
					state_next = EXECUTE;
				end else if (is_shift) begin
					state_next = SHIFT_LOAD;
				end else if (is_branch) begin
					state_next = BRANCH;
				end else begin
					state_next = FETCH;
				end
			end
			EXECUTE: begin
				ctrl.alu_out_write = 1'b1;
				ctrl.alu_src_a     = 1'b1;
				ctrl.alu_src_b     = is_imm ? SRC_B_IMM : SRC_B_REG;
				ctrl.alu_op        = exec_op;
				state_next         = WRITEBACK;
			end
			SHIFT_LOAD: begin
				ctrl.shift_op      = SH_LOAD;
				ctrl.shift_amt_reg = is_shift_var;
				state_next         = SHIFT_RUN;
			end
			SHIFT_RUN: begin
				ctrl.shift_op = run_op;
				state_next    = WRITEBACK;
			end
			BRANCH: begin
				// Flags come from A and B, the target from ALU-out.
				ctrl.alu_src_a = 1'b1;
				ctrl.alu_src_b = SRC_B_REG;
				ctrl.alu_op    = ALU_SUB;
				ctrl.pc_write  = branch_taken;
				state_next     = FETCH;
			end
			WRITEBACK: begin
				ctrl.reg_write = o_wb_valid;
				if (o_wb_valid) begin
					state_next = FETCH;
				end
			end
			default: begin
				state_next = FETCH;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= FETCH;
			fetch_req_q <= 1'b0;
			credits     <= TRACE_CREDITS;
		end else begin
			state       <= state_next;
			fetch_req_q <= (state == FETCH); // One pulse per fetch.
			credits     <= credits + credit_t'(i_wb_credit) - credit_t'(o_wb_valid);
		end
	end

endmodule

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

package core_pkg;

	// ============================================================
	// Datapath control encodings
	// ============================================================

	typedef logic [2:0] alu_op_t;

	localparam alu_op_t ALU_PASS = 3'b000; // Result is operand B.
	localparam alu_op_t ALU_ADD  = 3'b001;
	localparam alu_op_t ALU_SUB  = 3'b010;
	localparam alu_op_t ALU_AND  = 3'b011;
	localparam alu_op_t ALU_CMP  = 3'b111; // Signed less-than that slt uses.

	typedef logic [2:0] shift_op_t;

	localparam shift_op_t SH_HOLD        = 3'b000;
	localparam shift_op_t SH_LOAD        = 3'b001;
	localparam shift_op_t SH_LEFT        = 3'b010;
	localparam shift_op_t SH_RIGHT_LOG   = 3'b011;
	localparam shift_op_t SH_RIGHT_ARITH = 3'b100;

	typedef logic [1:0] src_b_sel_t;

	localparam src_b_sel_t SRC_B_REG    = 2'b00;
	localparam src_b_sel_t SRC_B_STEP   = 2'b01;
	localparam src_b_sel_t SRC_B_IMM    = 2'b10;
	localparam src_b_sel_t SRC_B_BRANCH = 2'b11; // Immediate times four.

	typedef logic wb_sel_t;

	localparam wb_sel_t WB_ALU_OUT = 1'b0;
	localparam wb_sel_t WB_SHIFT   = 1'b1;

	// Trace credits held by the core after reset.
	typedef logic [2:0] credit_t;

	localparam credit_t TRACE_CREDITS = 3'd4;

	typedef enum logic [2:0] {
		FETCH,
		WAIT_INSTR,
		DECODE,
		EXECUTE,
		SHIFT_LOAD,
		SHIFT_RUN,
		BRANCH,
		WRITEBACK
	} state_t;

endpackage

`default_nettype wire

//--- datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath (
	input  logic                clock,
	input  logic                reset,
	input  isa_pkg::word_t      i_fetch_instr,
	input  logic                i_fetch_valid,
	output isa_pkg::word_t      o_fetch_pc,
	output isa_pkg::reg_addr_t  o_wb_reg,
	output isa_pkg::word_t      o_wb_data,
	datapath_ctrl_if.dp         dp
);
	import isa_pkg::*;
	import core_pkg::*;

	word_t pc_q;
	word_t ir_q;
	word_t a_q;
	word_t b_q;
	word_t alu_out_q;

	word_t rs_data;
	word_t rt_data;
	word_t imm_ext;
	word_t branch_off;
	word_t src_a;
	word_t src_b;
	word_t alu_result;
	word_t shift_result;

	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	shamt_t    shamt;
	shamt_t    shift_amt;
	imm_t      imm;

	assign rs    = ir_q[25:21];
	assign rt    = ir_q[20:16];
	assign rd    = ir_q[15:11];
	assign shamt = ir_q[10:6];
	assign imm   = ir_q[15:0];

	assign dp.opcode = ir_q[31:26];
	assign dp.funct  = ir_q[5:0];

	assign imm_ext    = {{16{imm[15]}}, imm};
	assign branch_off = {imm_ext[29:0], 2'b00};

	// ============================================================
	// Operand and writeback selection
	// ============================================================

	assign src_a = dp.alu_src_a ? a_q : pc_q;

	always_comb begin
		case (dp.alu_src_b)
			SRC_B_STEP:   src_b = PC_STEP;
			SRC_B_IMM:    src_b = imm_ext;
			SRC_B_BRANCH: src_b = branch_off;
			default:      src_b = b_q;
		endcase
	end

	assign shift_amt = dp.shift_amt_reg ? a_q[4:0] : shamt;

	assign o_wb_reg   = dp.reg_dst_rd ? rd : rt;
	assign o_wb_data  = (dp.wb_sel == WB_SHIFT) ? shift_result : alu_out_q;
	assign o_fetch_pc = pc_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= RESET_PC;
		end else if (dp.pc_write) begin
			pc_q <= dp.ir_write ? alu_result : alu_out_q; // Step on fetch, target on branch.
		end
	end

	always_ff @(posedge clock) begin
		if (dp.ir_write && i_fetch_valid) begin
			ir_q <= i_fetch_instr;
		end
		if (dp.ab_write) begin
			a_q <= rs_data;
			b_q <= rt_data;
		end
		if (dp.alu_out_write) begin
			alu_out_q <= alu_result;
		end
	end

	register_file u_register_file (
		.clock     (clock),
		.reset     (reset),
		.i_rs      (rs),
		.i_rt      (rt),
		.i_rd_addr (o_wb_reg),
		.i_write   (dp.reg_write),
		.i_wdata   (o_wb_data),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	alu u_alu (
		.i_a       (src_a),
		.i_b       (src_b),
		.i_op      (dp.alu_op),
		.o_result  (alu_result),
		.o_equal   (dp.equal),
		.o_greater (dp.greater)
	);

	shifter u_shifter (
		.clock    (clock),
		.reset    (reset),
		.i_op     (dp.shift_op),
		.i_src    (b_q),
		.i_amt    (shift_amt),
		.o_result (shift_result)
	);

endmodule

`default_nettype wire

//--- datapath_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface datapath_ctrl_if;
	import isa_pkg::*;
	import core_pkg::*;

	logic       pc_write;
	logic       ir_write;
	logic       ab_write;
	logic       alu_out_write;
	logic       alu_src_a;     // Zero selects PC, one selects A.
	src_b_sel_t alu_src_b;
	alu_op_t    alu_op;
	shift_op_t  shift_op;
	logic       shift_amt_reg; // Shift amount from A instead of shamt.
	wb_sel_t    wb_sel;
	logic       reg_write;
	logic       reg_dst_rd;

	opcode_t opcode;
	funct_t  funct;
	logic    equal;
	logic    greater;

	modport ctrl (
		output pc_write, ir_write, ab_write, alu_out_write, alu_src_a, alu_src_b,
		output alu_op, shift_op, shift_amt_reg, wb_sel, reg_write, reg_dst_rd,
		input  opcode, funct, equal, greater
	);

	modport dp (
		input  pc_write, ir_write, ab_write, alu_out_write, alu_src_a, alu_src_b,
		input  alu_op, shift_op, shift_amt_reg, wb_sel, reg_write, reg_dst_rd,
		output opcode, funct, equal, greater
	);

endinterface

`default_nettype wire

//--- files.f
isa_pkg.sv
core_pkg.sv
datapath_ctrl_if.sv
register_file.sv
alu.sv
shifter.sv
control_fsm.sv
datapath.sv
mips_core.sv
mips_core_checker.sv
tb_mips_core.sv

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

	// ============================================================
	// Widths and instruction fields
	// ============================================================

	typedef logic [31:0] word_t; // Data and address word.
	typedef logic [4:0]  reg_addr_t;
	typedef logic [4:0]  shamt_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [15:0] imm_t;

	localparam int NUM_REGS = 32;

	localparam word_t RESET_PC = 32'h0000_0000;
	localparam word_t PC_STEP  = 32'd4;

	// ============================================================
	// Opcodes and function codes
	// ============================================================

	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_ADDI  = 6'b001000;
	localparam opcode_t OP_ADDIU = 6'b001001;
	localparam opcode_t OP_BEQ   = 6'b000100;
	localparam opcode_t OP_BNE   = 6'b000101;
	localparam opcode_t OP_BLE   = 6'b000110;
	localparam opcode_t OP_BGT   = 6'b000111;

	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_SRA  = 6'b000011;
	localparam funct_t FN_SLLV = 6'b000100;
	localparam funct_t FN_SRAV = 6'b000111;
	localparam funct_t FN_ADD  = 6'b100000;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_SLT  = 6'b101010;

endpackage

`default_nettype wire

//--- mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core (
	input  logic               clock,
	input  logic               reset,
	input  logic               i_fetch_valid,
	input  isa_pkg::word_t     i_fetch_instr,
	input  logic               i_wb_credit,
	output logic               o_fetch_req,
	output isa_pkg::word_t     o_fetch_pc,
	output logic               o_wb_valid,
	output isa_pkg::reg_addr_t o_wb_reg,
	output isa_pkg::word_t     o_wb_data
);

	datapath_ctrl_if ctrl_bus ();

	control_fsm u_control_fsm (
		.clock         (clock),
		.reset         (reset),
		.i_fetch_valid (i_fetch_valid),
		.i_wb_credit   (i_wb_credit),
		.o_fetch_req   (o_fetch_req),
		.o_wb_valid    (o_wb_valid),
		.ctrl          (ctrl_bus.ctrl)
	);

	datapath u_datapath (
		.clock         (clock),
		.reset         (reset),
		.i_fetch_instr (i_fetch_instr),
		.i_fetch_valid (i_fetch_valid),
		.o_fetch_pc    (o_fetch_pc),
		.o_wb_reg      (o_wb_reg),
		.o_wb_data     (o_wb_data),
		.dp            (ctrl_bus.dp)
	);

endmodule

`default_nettype wire

//--- mips_core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core_checker (
	input logic           clock,
	input logic           reset,
	input logic           i_fetch_req,
	input isa_pkg::word_t i_fetch_pc,
	input logic           i_fetch_valid,
	input logic           i_wb_valid,
	input logic           i_wb_credit
);
	import core_pkg::*;

	credit_t credits;       // Credits the consumer still grants.
	logic    fetch_pending;
	int      fail_count = 0; // Failed assertions so far.

	always_ff @(posedge clock) begin
		if (reset) begin
			credits       <= TRACE_CREDITS;
			fetch_pending <= 1'b0;
		end else begin
			credits <= credits + credit_t'(i_wb_credit) - credit_t'(i_wb_valid);
			if (i_fetch_req) begin
				fetch_pending <= 1'b1;
			end else if (i_fetch_valid) begin
				fetch_pending <= 1'b0;
			end
		end
	end

	// ============================================================
	// Trace and fetch handshake properties
	// ============================================================

	a_wb_needs_credit: assert property (@(posedge clock) disable iff (reset)
		i_wb_valid |-> (credits != '0))
		else begin
			$error("Trace entry issued while the consumer had no credit left.");
			fail_count++;
		end

	a_fetch_req_pulse: assert property (@(posedge clock) disable iff (reset)
		i_fetch_req |=> !i_fetch_req)
		else begin
			$error("Fetch request held longer than one cycle.");
			fail_count++;
		end

	a_fetch_req_single: assert property (@(posedge clock) disable iff (reset)
		fetch_pending |-> !i_fetch_req)
		else begin
			$error("New fetch request issued before the previous one was answered.");
			fail_count++;
		end

	a_fetch_pc_stable: assert property (@(posedge clock) disable iff (reset)
		fetch_pending |-> $stable(i_fetch_pc))
		else begin
			$error("Fetch address changed while a request was outstanding.");
			fail_count++;
		end

endmodule

bind mips_core mips_core_checker u_mips_core_checker (
	.clock         (clock),
	.reset         (reset),
	.i_fetch_req   (o_fetch_req),
	.i_fetch_pc    (o_fetch_pc),
	.i_fetch_valid (i_fetch_valid),
	.i_wb_valid    (o_wb_valid),
	.i_wb_credit   (i_wb_credit)
);

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  logic               clock,
	input  logic               reset,
	input  isa_pkg::reg_addr_t i_rs,
	input  isa_pkg::reg_addr_t i_rt,
	input  isa_pkg::reg_addr_t i_rd_addr,
	input  logic               i_write,
	input  isa_pkg::word_t     i_wdata,
	output isa_pkg::word_t     o_rs_data,
	output isa_pkg::word_t     o_rt_data
);
	import isa_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_write && (i_rd_addr != '0)) begin
			regs[i_rd_addr] <= i_wdata; // Register 0 is never written.
		end
	end

	assign o_rs_data = regs[i_rs];
	assign o_rt_data = regs[i_rt];

endmodule

`default_nettype wire

//--- shifter.sv
`timescale 1ns/1ns
`default_nettype none

module shifter (
	input  logic                clock,
	input  logic                reset,
	input  core_pkg::shift_op_t i_op,
	input  isa_pkg::word_t      i_src,
	input  isa_pkg::shamt_t     i_amt,
	output isa_pkg::word_t      o_result
);
	import isa_pkg::*;
	import core_pkg::*;

	word_t  value_q;
	shamt_t amt_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			value_q <= '0;
			amt_q   <= '0;
		end else begin
			case (i_op)
				SH_LOAD: begin
					value_q <= i_src;
					amt_q   <= i_amt;
				end
				SH_LEFT:        value_q <= value_q << amt_q;
				SH_RIGHT_LOG:   value_q <= value_q >> amt_q;
				SH_RIGHT_ARITH: value_q <= word_t'($signed(value_q) >>> amt_q);
				default:        value_q <= value_q; // Hold.
			endcase
		end
	end

	assign o_result = value_q;

endmodule

`default_nettype wire

//--- tb_mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core;
	import isa_pkg::*;
	import core_pkg::*;

	localparam int      PROG_LEN    = 43;
	localparam int      CYCLE_LIMIT = PROG_LEN * 400;
	localparam word_t   HALT_PC     = word_t'((PROG_LEN - 1) * 4);
	localparam opcode_t OP_STORE    = 6'b101011; // Store word opcode that the core runs as a no-op.

	logic      clock;
	logic      reset;
	logic      fetch_valid;
	word_t     fetch_instr;
	logic      wb_credit;
	logic      fetch_req;
	word_t     fetch_pc;
	logic      wb_valid;
	reg_addr_t wb_reg;
	word_t     wb_data;

	integer seed = 63040;
	int     check_count = 0;
	int     error_count = 0;
	logic   done = 1'b0;

	word_t        prog_mem [PROG_LEN];
	word_t        model_regs [NUM_REGS];
	word_t        model_pc;
	logic [36:0]  expected_q [$]; // {register, data} of each expected trace entry.

	mips_core u_mips_core (
		.clock         (clock),
		.reset         (reset),
		.i_fetch_valid (fetch_valid),
		.i_fetch_instr (fetch_instr),
		.i_wb_credit   (wb_credit),
		.o_fetch_req   (fetch_req),
		.o_fetch_pc    (fetch_pc),
		.o_wb_valid    (wb_valid),
		.o_wb_reg      (wb_reg),
		.o_wb_data     (wb_data)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// ============================================================
	// Program and reference model
	// ============================================================

	function automatic word_t rtype_word(funct_t fn, reg_addr_t rd, reg_addr_t rs,
			reg_addr_t rt, shamt_t sa);
		return {OP_RTYPE, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t itype_word(opcode_t op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic load_program;
		prog_mem[0]  = itype_word(OP_ADDI, 0, 1, 16'd100);
		prog_mem[1]  = itype_word(OP_ADDI, 0, 2, -16'd7);
		prog_mem[2]  = itype_word(OP_ADDIU, 0, 3, 16'h7FFF);
		prog_mem[3]  = itype_word(OP_ADDIU, 1, 4, -16'd200);
		prog_mem[4]  = rtype_word(FN_ADD, 5, 1, 2, 0);
		prog_mem[5]  = rtype_word(FN_SUB, 6, 2, 1, 0);
		prog_mem[6]  = rtype_word(FN_AND, 7, 3, 2, 0);
		prog_mem[7]  = rtype_word(FN_SLT, 8, 2, 1, 0);   // Negative against positive.
		prog_mem[8]  = rtype_word(FN_SLT, 9, 1, 4, 0);
		prog_mem[9]  = rtype_word(FN_SLT, 10, 4, 2, 0);  // Both negative.
		prog_mem[10] = rtype_word(FN_SLL, 11, 0, 3, 4);
		prog_mem[11] = rtype_word(FN_SRL, 12, 0, 2, 28);
		prog_mem[12] = rtype_word(FN_SRA, 13, 0, 2, 2);
		prog_mem[13] = itype_word(OP_ADDI, 0, 14, 16'd9);
		prog_mem[14] = rtype_word(FN_SLLV, 15, 14, 1, 0);
		prog_mem[15] = rtype_word(FN_SRAV, 16, 14, 4, 0);
		prog_mem[16] = rtype_word(FN_SRA, 17, 0, 6, 31);
		prog_mem[17] = rtype_word(FN_ADD, 0, 1, 1, 0);   // Write to register 0.
		prog_mem[18] = rtype_word(FN_ADD, 18, 0, 1, 0);
		prog_mem[19] = itype_word(OP_ADDI, 0, 0, 16'd55);
		prog_mem[20] = rtype_word(FN_SUB, 19, 0, 2, 0);
		prog_mem[21] = itype_word(OP_STORE, 1, 2, 16'd4);
		prog_mem[22] = itype_word(OP_BEQ, 1, 2, 16'd2);  // Not taken.
		prog_mem[23] = itype_word(OP_ADDI, 0, 20, 16'd1);
		prog_mem[24] = itype_word(OP_ADDI, 0, 20, 16'd2);
		prog_mem[25] = itype_word(OP_BNE, 1, 18, 16'd5);
		prog_mem[26] = itype_word(OP_BNE, 1, 2, 16'd1);
		prog_mem[27] = itype_word(OP_ADDI, 0, 20, 16'd3);
		prog_mem[28] = itype_word(OP_BLE, 2, 1, 16'd1);
		prog_mem[29] = itype_word(OP_ADDI, 0, 20, 16'd4);
		prog_mem[30] = itype_word(OP_BLE, 1, 2, 16'd3);
		prog_mem[31] = itype_word(OP_BGT, 1, 2, 16'd1);
		prog_mem[32] = itype_word(OP_ADDI, 0, 20, 16'd5);
		prog_mem[33] = itype_word(OP_BGT, 2, 1, 16'd4);
		prog_mem[34] = itype_word(OP_ADDI, 0, 21, 16'd3);
		prog_mem[35] = itype_word(OP_ADDI, 22, 22, 16'd10);
		prog_mem[36] = itype_word(OP_ADDI, 21, 21, -16'd1);
		prog_mem[37] = itype_word(OP_BGT, 21, 0, -16'd3); // Loop runs three times.
		prog_mem[38] = itype_word(OP_BEQ, 21, 0, 16'd1);
		prog_mem[39] = itype_word(OP_ADDI, 0, 20, 16'd6);
		prog_mem[40] = itype_word(OP_BLE, 22, 0, -16'd5);
		prog_mem[41] = rtype_word(FN_SLT, 23, 0, 22, 0);
		prog_mem[42] = itype_word(OP_BEQ, 0, 0, -16'd1);  // Branch to itself.
	endtask

	function automatic word_t program_word(word_t addr);
		if (addr[31:2] < PROG_LEN) begin
			return prog_mem[addr[31:2]];
		end
		return {OP_STORE, addr[27:2] ^ {addr[31:28], 22'd0}};
	endfunction

	function automatic void model_step(input word_t instr, input word_t pc,
			output logic exp_valid, output reg_addr_t exp_reg, output word_t exp_data,
			output word_t next_pc);
		reg_addr_t rs;
		reg_addr_t rt;
		shamt_t    sa;
		word_t     a;
		word_t     b;
		word_t     imm_ext;
		word_t     target;

		rs        = instr[25:21];
		rt        = instr[20:16];
		sa        = instr[10:6];
		a         = model_regs[rs];
		b         = model_regs[rt];
		imm_ext   = {{16{instr[15]}}, instr[15:0]};
		target    = pc + 32'd4 + (imm_ext << 2);
		exp_valid = 1'b0;
		exp_reg   = '0;
		exp_data  = '0;
		next_pc   = pc + 32'd4;
		case (instr[31:26])
			OP_RTYPE: begin
				exp_valid = 1'b1;
				exp_reg   = instr[15:11];
				case (instr[5:0])
					FN_ADD:  exp_data = a + b;
					FN_SUB:  exp_data = a - b;
					FN_AND:  exp_data = a & b;
					FN_SLT:  exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FN_SLL:  exp_data = b << sa;
					FN_SRL:  exp_data = b >> sa;
					FN_SRA:  exp_data = $signed(b) >>> sa;
					FN_SLLV: exp_data = b << a[4:0];
					FN_SRAV: exp_data = $signed(b) >>> a[4:0];
					default: exp_valid = 1'b0;
				endcase
			end
			OP_ADDI, OP_ADDIU: begin
				exp_valid = 1'b1;
				exp_reg   = rt;
				exp_data  = a + imm_ext;
			end
			OP_BEQ: next_pc = (a == b) ? target : next_pc;
			OP_BNE: next_pc = (a != b) ? target : next_pc;
			OP_BLE: next_pc = ($signed(a) <= $signed(b)) ? target : next_pc;
			OP_BGT: next_pc = ($signed(a) > $signed(b)) ? target : next_pc;
			default: ;
		endcase
		if (exp_valid && (exp_reg != '0)) begin
			model_regs[exp_reg] = exp_data; // Register 0 keeps zero.
		end
	endfunction

	task automatic compare_value(input string name, input word_t actual, input word_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	// ============================================================
	// Stimulus, comparison and run control
	// ============================================================

	initial begin
		reset       = 1'b1;
		fetch_valid = 1'b0;
		fetch_instr = '0;
		wb_credit   = 1'b0;
		load_program();
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		wait (done);
		repeat (4) @(posedge clock);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
			u_mips_core.u_mips_core_checker.fail_count);
		if ((error_count == 0) && (u_mips_core.u_mips_core_checker.fail_count == 0)) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Instruction memory with a random answer delay of 0 to 3 cycles.
	initial begin : fetch_memory
		int    delay;
		word_t addr;

		wait (reset === 1'b0);
		forever begin
			@(posedge clock);
			if (fetch_req) begin
				addr  = fetch_pc;
				delay = {$random(seed)} % 4;
				repeat (delay) @(posedge clock);
				fetch_valid <= 1'b1;
				fetch_instr <= program_word(addr);
				@(posedge clock);
				fetch_valid <= 1'b0;
			end
		end
	end

	// Credits go back with random gaps, and long holds drain the core's counter.
	initial begin : credit_return
		int owed;
		int hold_left;

		owed      = 0;
		hold_left = 60;
		wait (reset === 1'b0);
		forever begin
			@(posedge clock);
			if (wb_valid) begin
				owed++;
			end
			if (owed > TRACE_CREDITS) begin
				error_count++;
				$display("More trace entries arrived than credits were granted at %0t", $time);
			end
			if (hold_left > 0) begin
				hold_left--;
				wb_credit <= 1'b0;
			end else if ({$random(seed)} % 20 == 0) begin
				hold_left = 30 + {$random(seed)} % 31;
				wb_credit <= 1'b0;
			end else if ((owed > 0) && ({$random(seed)} % 2 == 0)) begin
				owed--;
				wb_credit <= 1'b1;
			end else begin
				wb_credit <= 1'b0;
			end
		end
	end

	initial begin : compare_results
		logic        exp_valid;
		reg_addr_t   exp_reg;
		word_t       exp_data;
		word_t       next_pc;
		logic [36:0] entry;

		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		model_pc = RESET_PC;
		wait (reset === 1'b0);
		forever begin
			@(posedge clock);
			if (wb_valid) begin
				if (expected_q.size() == 0) begin
					error_count++;
					$display("Unexpected trace entry for register %0d at %0t", wb_reg, $time);
				end else begin
					entry = expected_q.pop_front();
					compare_value("o_wb_reg", word_t'(wb_reg), word_t'(entry[36:32]));
					compare_value("o_wb_data", wb_data, entry[31:0]);
				end
			end
			if (fetch_req && !done) begin
				compare_value("o_fetch_pc", fetch_pc, model_pc);
				if (model_pc == HALT_PC) begin
					if (expected_q.size() != 0) begin
						error_count++;
						$display("%0d expected trace entries never appeared.", expected_q.size());
					end
					done = 1'b1;
				end else begin
					model_step(program_word(model_pc), model_pc, exp_valid, exp_reg, exp_data,
						next_pc);
					if (exp_valid) begin
						expected_q.push_back({exp_reg, exp_data});
					end
					model_pc = next_pc;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (CYCLE_LIMIT) @(posedge clock);
		$display("Timeout: the program did not reach its last instruction in %0d cycles.",
			CYCLE_LIMIT);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
